// File: hdl/lsq_pkg.sv
// Shared types of the queue; sequence numbers are assumed wide enough never to wrap in a run
`default_nettype none

package lsq_pkg;

	// ======================================================================
	// Widths with a meaning of their own
	// ======================================================================

	// Physical address of a load or a store
	typedef logic [31:0] padr_t;

	// Program-order sequence number given out at allocation
	// Older operations always hold the smaller number
	typedef logic [15:0] seq_t;

	// Queue depth used when the top level is not told otherwise
	localparam int LSQ_ENTRIES_DEF = 8;

	// ======================================================================
	// Queue entry and configuration
	// ======================================================================

	// One queue entry as the overlap checker sees it
	// The address and the sequence number are only meaningful while valid is set
	typedef struct packed {
		logic  valid;
		logic  load;
		logic  agen;
		padr_t padr;
		seq_t  sn;
	} lsq_entry_t;

	// Checker settings
	// With line_gran clear the compare works on 16-byte blocks, bits 31 down to 4
	// With line_gran set it works on 64-byte lines, bits 31 down to 6
	typedef struct packed {
		logic line_gran;
		logic loads_may_overlap;
	} lsq_cfg_t;

	// Out of reset the checker compares 16-byte blocks and lets loads pass each other
	localparam lsq_cfg_t LSQ_CFG_RESET = '{
		line_gran:         1'b0,
		loads_may_overlap: 1'b1
	};

endpackage

`default_nettype wire

// File: hdl/lsq_cfg.sv
// Checker configuration register; a write steers queries only from the cycle after the write
`timescale 1ns/1ps
`default_nettype none

module lsq_cfg (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    cfg_wr,
	input  wire lsq_pkg::lsq_cfg_t cfg_data,
	output lsq_pkg::lsq_cfg_t      cfg
);
	import lsq_pkg::*;

	// Current settings, read by the checker in every cycle
	lsq_cfg_t cfg_q;

	// ======================================================================
	// Register
	// ======================================================================

	// The whole word is written at once, there are no partial updates
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= LSQ_CFG_RESET;
		end else if (cfg_wr) begin
			cfg_q <= cfg_data;
		end
	end

	// The checker sees the register directly with no further decode
	assign cfg = cfg_q;

	// ======================================================================
	// Checks
	// ======================================================================

	// The settings only move on a write, so a query result cannot change
	// behind the back of the issue logic
	a_cfg_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!cfg_wr |=> $stable(cfg))
		else $error("lsq_cfg changed without a write");

endmodule

`default_nettype wire

// File: hdl/lsq_queue.sv
// Entry storage of the load/store queue; alloc while full is dropped and wrap of sn is not handled
`timescale 1ns/1ps
`default_nettype none

module lsq_queue #(
	parameter  int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES_DEF,
	localparam int NDX_W       = $clog2(LSQ_ENTRIES)
) (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  alloc,
	input  wire                  alloc_load,
	output logic [NDX_W-1:0]     alloc_ndx,
	output logic                 full,
	input  wire                  agen_wr,
	input  wire  [NDX_W-1:0]     agen_ndx,
	input  wire  lsq_pkg::padr_t agen_padr,
	input  wire                  done_wr,
	input  wire  [NDX_W-1:0]     done_ndx,
	output lsq_pkg::lsq_entry_t  entries [LSQ_ENTRIES]
);
	import lsq_pkg::*;

	// Per-entry state bits that must be known after reset
	logic [LSQ_ENTRIES-1:0] valid_q;
	logic [LSQ_ENTRIES-1:0] agen_q;

	// Per-entry payload, only read while the entry is valid
	logic [LSQ_ENTRIES-1:0] load_q;
	padr_t                  padr_q [LSQ_ENTRIES];
	seq_t                   sn_q   [LSQ_ENTRIES];

	// Next sequence number to hand out
	seq_t seq_cnt_q;

	// Result of the free slot search
	logic free_found;
	logic alloc_ok;

	// ======================================================================
	// Free slot search
	// ======================================================================

	// The lowest free slot wins
	// Once a slot has been found the later ones are ignored
	always_comb begin
		alloc_ndx  = '0;
		free_found = 1'b0;
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			if (!valid_q[i] && !free_found) begin
				alloc_ndx  = NDX_W'(i);
				free_found = 1'b1;
			end
		end
	end

	// No free slot means every entry is live
	assign full = ~free_found;

	// An allocation while full is dropped here as well as flagged below
	assign alloc_ok = alloc && free_found;

	// ======================================================================
	// Entry state and sequence counter
	// ======================================================================

	// A new entry starts without an address
	// The address write and the retire never touch the slot being allocated,
	// since both only address live entries
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q   <= '0;
			agen_q    <= '0;
			seq_cnt_q <= '0;
		end else begin
			if (alloc_ok) begin
				valid_q[alloc_ndx] <= 1'b1;
				agen_q[alloc_ndx]  <= 1'b0;
				seq_cnt_q          <= seq_cnt_q + seq_t'(1);
			end
			if (agen_wr) begin
				agen_q[agen_ndx] <= 1'b1;
			end
			// Retire frees the slot for the next cycle
			if (done_wr) begin
				valid_q[done_ndx] <= 1'b0;
			end
		end
	end

	// Payload is written with the strobe that makes it meaningful
	always_ff @(posedge clk) begin
		if (alloc_ok) begin
			load_q[alloc_ndx] <= alloc_load;
			sn_q[alloc_ndx]   <= seq_cnt_q;
		end
		if (agen_wr) begin
			padr_q[agen_ndx] <= agen_padr;
		end
	end

	// Gather the fields into the entry view for the checker
	always_comb begin
		for (int i = 0; i < LSQ_ENTRIES; i++) begin
			entries[i].valid = valid_q[i];
			entries[i].load  = load_q[i];
			entries[i].agen  = agen_q[i];
			entries[i].padr  = padr_q[i];
			entries[i].sn    = sn_q[i];
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// The issue logic has to watch full before it allocates
	a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
		alloc |-> !full)
		else $error("lsq_queue alloc while full");

	// An address can only be written to an entry that was allocated earlier
	a_agen_live: assert property (@(posedge clk) disable iff (!arst_n)
		agen_wr |-> valid_q[agen_ndx])
		else $error("lsq_queue agen_wr to a free slot");

	// A retire can only name an entry that is still live
	a_done_live: assert property (@(posedge clk) disable iff (!arst_n)
		done_wr |-> valid_q[done_ndx])
		else $error("lsq_queue done_wr to a free slot");

	// A retire and an allocation of the same slot in one cycle would lose the new entry
	a_done_not_alloc: assert property (@(posedge clk) disable iff (!arst_n)
		(alloc_ok && done_wr) |-> (done_ndx != alloc_ndx))
		else $error("lsq_queue done_wr hits the slot being allocated");

endmodule

`default_nettype wire

// File: hdl/lsq_overlap_check.sv
// Combinational overlap check of one queried entry; the result is only meaningful for a live, generated entry
`timescale 1ns/1ps
`default_nettype none

module lsq_overlap_check #(
	parameter  int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES_DEF,
	localparam int NDX_W       = $clog2(LSQ_ENTRIES)
) (
	input  wire lsq_pkg::lsq_entry_t entries [LSQ_ENTRIES],
	input  wire lsq_pkg::lsq_cfg_t   cfg,
	input  wire [NDX_W-1:0]          query_ndx,
	output logic                     has_overlap
);
	import lsq_pkg::*;

	// Address masks for the two compare granularities
	localparam padr_t BLK16_MASK = ~padr_t'(32'h0000_000F);
	localparam padr_t BLK64_MASK = ~padr_t'(32'h0000_003F);

	// The entry under test
	lsq_entry_t qry;

	// Mask that drops the offset inside a block or line
	padr_t blk_mask;

	// Per-entry reasons to hold the queried operation back
	logic [LSQ_ENTRIES-1:0] older;
	logic [LSQ_ENTRIES-1:0] unknown;
	logic [LSQ_ENTRIES-1:0] same_blk;
	logic [LSQ_ENTRIES-1:0] conflict;

	assign qry      = entries[query_ndx];
	assign blk_mask = cfg.line_gran ? BLK64_MASK : BLK16_MASK;

	// ======================================================================
	// Scan of all entries
	// ======================================================================

	always_comb begin
		for (int n = 0; n < LSQ_ENTRIES; n++) begin
			// Retired entries and younger operations never hold the query back
			// The queried entry itself drops out here since its sn is not smaller
			older[n] = entries[n].valid && (entries[n].sn < qry.sn);

			// Without an address nothing is known, so assume the worst
			unknown[n] = older[n] && !entries[n].agen;

			// Same block or line as the query at the configured granularity
			same_blk[n] = (entries[n].padr & blk_mask) == (qry.padr & blk_mask);

			// A matching older entry blocks unless both are loads and that is allowed
			conflict[n] = older[n] && entries[n].agen && same_blk[n] &&
				!(entries[n].load && qry.load && cfg.loads_may_overlap);
		end
	end

	// Any single reason is enough to make the operation wait
	assign has_overlap = |(unknown | conflict);

endmodule

`default_nettype wire

// File: hdl/lsq_top.sv
// Load/store queue with overlap check; query_ndx must name a live entry with an address when it moves
`timescale 1ns/1ps
`default_nettype none

module lsq_top #(
	parameter  int LSQ_ENTRIES = lsq_pkg::LSQ_ENTRIES_DEF,
	localparam int NDX_W       = $clog2(LSQ_ENTRIES)
) (
	input  wire                    clk,
	input  wire                    arst_n,
	// Configuration write
	input  wire                    cfg_wr,
	input  wire lsq_pkg::lsq_cfg_t cfg_data,
	// Allocation in program order
	input  wire                    alloc,
	input  wire                    alloc_load,
	output logic [NDX_W-1:0]       alloc_ndx,
	output logic                   full,
	// Address generation result
	input  wire                    agen_wr,
	input  wire [NDX_W-1:0]        agen_ndx,
	input  wire lsq_pkg::padr_t    agen_padr,
	// Retire
	input  wire                    done_wr,
	input  wire [NDX_W-1:0]        done_ndx,
	// Overlap query
	input  wire [NDX_W-1:0]        query_ndx,
	output logic                   has_overlap
);
	import lsq_pkg::*;

	// Entry view from the queue to the checker
	lsq_entry_t entries [LSQ_ENTRIES];

	// Current checker settings
	lsq_cfg_t cfg;

	// ======================================================================
	// Blocks
	// ======================================================================

	lsq_cfg i_cfg (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg_wr   (cfg_wr),
		.cfg_data (cfg_data),
		.cfg      (cfg)
	);

	lsq_queue #(
		.LSQ_ENTRIES (LSQ_ENTRIES)
	) i_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.alloc      (alloc),
		.alloc_load (alloc_load),
		.alloc_ndx  (alloc_ndx),
		.full       (full),
		.agen_wr    (agen_wr),
		.agen_ndx   (agen_ndx),
		.agen_padr  (agen_padr),
		.done_wr    (done_wr),
		.done_ndx   (done_ndx),
		.entries    (entries)
	);

	lsq_overlap_check #(
		.LSQ_ENTRIES (LSQ_ENTRIES)
	) i_check (
		.entries     (entries),
		.cfg         (cfg),
		.query_ndx   (query_ndx),
		.has_overlap (has_overlap)
	);

	// A new query is presented when query_ndx moves
	// It must then name an entry that the queue holds with its address written
	a_query_live: assert property (@(posedge clk) disable iff (!arst_n)
		!$stable(query_ndx) |-> (entries[query_ndx].valid && entries[query_ndx].agen))
		else $error("lsq_top query of an entry that is free or has no address");

endmodule

`default_nettype wire

// File: tb/lsq_tb.sv
// Testbench for lsq_top; checks run as concurrent assertions against a model, so assertions must be enabled
`timescale 1ns/1ps
`default_nettype none

module lsq_tb;
	import lsq_pkg::*;

	localparam int N        = LSQ_ENTRIES_DEF;
	localparam int NDX_W    = $clog2(N);
	localparam int WAIT_MAX = 50;

	// Entry selection rules for the random run
	localparam int PICK_NOADR = 0;
	localparam int PICK_LIVE  = 1;
	localparam int PICK_READY = 2;

	typedef logic [NDX_W-1:0] ndx_t;

	logic     clk = 1'b0;
	logic     arst_n = 1'b0;
	logic     cfg_wr = 1'b0;
	lsq_cfg_t cfg_data = LSQ_CFG_RESET;
	logic     alloc = 1'b0;
	logic     alloc_load = 1'b0;
	ndx_t     alloc_ndx;
	logic     full;
	logic     agen_wr = 1'b0;
	ndx_t     agen_ndx = '0;
	padr_t    agen_padr = '0;
	logic     done_wr = 1'b0;
	ndx_t     done_ndx = '0;
	ndx_t     query_ndx = '0;
	logic     has_overlap;

	// Reference model of the queue and the configuration
	lsq_entry_t m_ent [N];
	seq_t       m_cnt;
	lsq_cfg_t   m_cfg;
	ndx_t       m_free_ndx;
	logic       exp_full;
	logic       exp_overlap;
	logic       q_live;

	int err_cnt = 0;
	int timeouts = 0;
	int chk_cnt = 0;
	int test_cnt = 0;
	int err_mark = 0;

	lsq_top #(.LSQ_ENTRIES(N)) i_dut (
		.clk(clk), .arst_n(arst_n), .cfg_wr(cfg_wr), .cfg_data(cfg_data),
		.alloc(alloc), .alloc_load(alloc_load), .alloc_ndx(alloc_ndx), .full(full),
		.agen_wr(agen_wr), .agen_ndx(agen_ndx), .agen_padr(agen_padr),
		.done_wr(done_wr), .done_ndx(done_ndx),
		.query_ndx(query_ndx), .has_overlap(has_overlap)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Block number at the chosen granularity, offset bits cleared
	function automatic padr_t block_of(input padr_t a, input logic line);
		return line ? {a[31:6], 6'b0} : {a[31:4], 4'b0};
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N; i++) begin
				m_ent[i] <= '0;
			end
			m_cnt <= '0;
			m_cfg <= LSQ_CFG_RESET;
		end else begin
			if (cfg_wr) begin
				m_cfg <= cfg_data;
			end
			if (alloc && !exp_full) begin
				m_ent[m_free_ndx] <= '{valid: 1'b1, load: alloc_load, agen: 1'b0,
					padr: '0, sn: m_cnt};
				m_cnt <= m_cnt + 16'd1;
			end
			if (agen_wr) begin
				m_ent[agen_ndx].agen <= 1'b1;
				m_ent[agen_ndx].padr <= agen_padr;
			end
			if (done_wr) begin
				m_ent[done_ndx].valid <= 1'b0;
			end
		end
	end

	// Lowest free slot, and full when there is none
	always_comb begin
		m_free_ndx = '0;
		exp_full   = 1'b1;
		for (int i = 0; i < N; i++) begin
			if (!m_ent[i].valid && exp_full) begin
				m_free_ndx = ndx_t'(i);
				exp_full   = 1'b0;
			end
		end
	end

	// An older live entry holds the query back if it has no address yet,
	// or if it shares the block and is not a load beside a load that may pass
	always_comb begin
		exp_overlap = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (m_ent[i].valid && m_ent[i].sn < m_ent[query_ndx].sn) begin
				if (!m_ent[i].agen) begin
					exp_overlap = 1'b1;
				end else if (block_of(m_ent[i].padr, m_cfg.line_gran) ==
						block_of(m_ent[query_ndx].padr, m_cfg.line_gran) &&
						!(m_ent[i].load && m_ent[query_ndx].load && m_cfg.loads_may_overlap)) begin
					exp_overlap = 1'b1;
				end
			end
		end
	end

	assign q_live = m_ent[query_ndx].valid && m_ent[query_ndx].agen;

	always @(posedge clk) begin
		if (arst_n && q_live) begin
			chk_cnt <= chk_cnt + 1;
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	a_full: assert property (@(posedge clk) disable iff (!arst_n) full == exp_full)
		else begin
			err_cnt++;
			$display("ERR %0t: full is %0b, expected %0b", $time, $sampled(full),
				$sampled(exp_full));
		end

	a_alloc_ndx: assert property (@(posedge clk) disable iff (!arst_n)
		!exp_full |-> alloc_ndx == m_free_ndx)
		else begin
			err_cnt++;
			$display("ERR %0t: alloc_ndx is %0d, expected %0d", $time, $sampled(alloc_ndx),
				$sampled(m_free_ndx));
		end

	a_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		q_live |-> has_overlap == exp_overlap)
		else begin
			err_cnt++;
			$display("ERR %0t: has_overlap for entry %0d is %0b, expected %0b", $time,
				$sampled(query_ndx), $sampled(has_overlap), $sampled(exp_overlap));
		end

	// ======================================================================
	// Stimulus tasks
	// ======================================================================

	// Every strobe lasts one cycle and is driven 2 ns after the edge
	task automatic tick();
		@(posedge clk);
		#2;
		cfg_wr  = 1'b0;
		alloc   = 1'b0;
		agen_wr = 1'b0;
		done_wr = 1'b0;
	endtask

	task automatic allocate(input logic ld, output ndx_t ndx);
		int cyc;
		cyc = 0;
		while (full && cyc < WAIT_MAX) begin
			tick();
			cyc++;
		end
		ndx = m_free_ndx;
		if (full) begin
			timeouts++;
			$display("Timeout: the queue stayed full for %0d cycles, allocation skipped",
				WAIT_MAX);
		end else begin
			alloc      = 1'b1;
			alloc_load = ld;
			tick();
		end
	endtask

	task automatic set_address(input ndx_t ndx, input padr_t a);
		agen_wr   = 1'b1;
		agen_ndx  = ndx;
		agen_padr = a;
		tick();
	endtask

	task automatic retire(input ndx_t ndx);
		done_wr  = 1'b1;
		done_ndx = ndx;
		tick();
	endtask

	task automatic configure(input logic line, input logic lmo);
		cfg_wr   = 1'b1;
		cfg_data = '{line_gran: line, loads_may_overlap: lmo};
		tick();
	endtask

	// The queried entry must already be live with its address written
	task automatic query(input ndx_t ndx);
		query_ndx = ndx;
		tick();
	endtask

	// Retire everything and go back to the reset configuration
	task automatic flush();
		ndx_t j;
		j = '0;
		repeat (N) begin
			if (m_ent[j].valid) begin
				retire(j);
			end
			j = j + 1'b1;
		end
		configure(LSQ_CFG_RESET.line_gran, LSQ_CFG_RESET.loads_may_overlap);
	endtask

	task automatic finish_test(input string name);
		int errs;
		tick();
		errs = err_cnt + timeouts - err_mark;
		test_cnt++;
		$display("test %0d %s: %s (%0d errors)", test_cnt, name,
			errs == 0 ? "ok" : "failed", errs);
		err_mark = err_cnt + timeouts;
		flush();
	endtask

	// Random entry that fits the rule, searched from a random start
	function automatic logic pick(input int kind, output ndx_t ndx);
		ndx_t j;
		logic hit;
		logic found;
		j     = ndx_t'($urandom % N);
		ndx   = '0;
		found = 1'b0;
		repeat (N) begin
			case (kind)
				PICK_NOADR: hit = m_ent[j].valid && !m_ent[j].agen;
				PICK_LIVE:  hit = m_ent[j].valid;
				default:    hit = m_ent[j].valid && m_ent[j].agen;
			endcase
			if (hit && !found) begin
				ndx   = j;
				found = 1'b1;
			end
			j = j + 1'b1;
		end
		return found;
	endfunction

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		ndx_t s;
		ndx_t l;
		ndx_t j;
		void'($urandom(70));
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		tick();

		// Older store without an address, then it lands in another block
		allocate(1'b0, s);
		allocate(1'b1, l);
		set_address(l, 32'h0000_0100);
		query(l);
		set_address(s, 32'h0000_0200);
		finish_test("unknown address");

		// Same block both ways round, then the load moves to the next block
		allocate(1'b0, s);
		allocate(1'b1, l);
		set_address(s, 32'h0000_0300);
		set_address(l, 32'h0000_0308);
		query(l);
		query(s);
		set_address(l, 32'h0000_0318);
		query(l);
		finish_test("block match");

		allocate(1'b1, s);
		allocate(1'b1, l);
		set_address(s, 32'h0000_0400);
		set_address(l, 32'h0000_0404);
		query(l);
		configure(1'b0, 1'b0);
		finish_test("load pairs");

		// 32 bytes apart inside one 64-byte line
		allocate(1'b0, s);
		allocate(1'b1, l);
		set_address(s, 32'h0000_0500);
		set_address(l, 32'h0000_0520);
		query(l);
		configure(1'b1, 1'b1);
		finish_test("granularity");

		allocate(1'b0, s);
		allocate(1'b1, l);
		set_address(s, 32'h0000_0600);
		set_address(l, 32'h0000_0604);
		query(l);
		retire(s);
		for (int k = 0; k < N; k++) begin
			if (!full) begin
				allocate(1'b0, j);
			end
		end
		tick();
		retire(j);
		finish_test("retire and full");

		// Addresses from 256 bytes so that blocks and lines match often
		for (int cyc = 0; cyc < 300; cyc++) begin
			if ($urandom % 2 == 0 && !full) begin
				alloc      = 1'b1;
				alloc_load = 1'($urandom);
			end
			if ($urandom % 2 == 0 && pick(PICK_NOADR, j)) begin
				agen_wr   = 1'b1;
				agen_ndx  = j;
				agen_padr = 32'h0000_1000 + ($urandom % 256);
			end
			if ($urandom % 3 == 0 && pick(PICK_LIVE, j)) begin
				done_wr  = 1'b1;
				done_ndx = j;
			end
			if ($urandom % 16 == 0) begin
				cfg_wr   = 1'b1;
				cfg_data = lsq_cfg_t'(2'($urandom));
			end
			if ($urandom % 2 == 0 && pick(PICK_READY, j)) begin
				query_ndx = j;
			end
			tick();
		end
		finish_test("random run");

		$display("tests %0d, checked cycles %0d, errors %0d, timeouts %0d",
			test_cnt, chk_cnt, err_cnt, timeouts);
		if (err_cnt == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hdl/lsq_pkg.sv
hdl/lsq_cfg.sv
hdl/lsq_queue.sv
hdl/lsq_overlap_check.sv
hdl/lsq_top.sv
tb/lsq_tb.sv

// File: Makefile
# Verilator flow for the load/store queue testbench
# The run target fails unless the log holds the pass line

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module lsq_tb \
		-f build.f --Mdir obj_dir -o lsq_sim

run: compile
	./obj_dir/lsq_sim | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
